//--- Bender.yml
package:
  name: adc_capture

sources:
  - hdl/capture_pkg.sv
  - hdl/sample_fifo.sv
  - hdl/capture_fsm.sv
  - hdl/word_packer.sv
  - hdl/error_tracker.sv
  - hdl/adc_capture_top.sv
  - target: simulation
    files:
      - dv/adc_capture_checker.sv
      - dv/tb_adc_capture.sv

//--- dv/adc_capture_checker.sv
`timescale 1ns/1ps

module adc_capture_checker import capture_pkg::*; (
    input logic           adc_sampleclk,
    input logic           reset,
    input sample_t        adc_data_i,
    input logic           arm_i,
    input logic           capture_go_i,
    input capture_cfg_t   cfg_i,
    input word_t          word_i,
    input logic           word_valid_i,
    input logic           armed_i,
    input logic           capture_done_i,
    input capture_state_e state_i,
    input logic           error_flag_i,
    input error_bits_t    error_stat_i,
    input error_bits_t    first_error_stat_i,
    input capture_state_e first_error_state_i,
    input sample_t        sample_i,          // FIFO read data into the packer
    input logic           sample_valid_i
);

    int      fail_count = 0;
    int      word_cnt;      // words seen in this capture
    int      arm_cyc;       // cycles since armed_i rose
    sample_t trig_val;
    logic    trig_seen;
    logic    late_trig;     // presample history was full at the trigger
    logic    trig_evt;
    logic    new_arm;
    logic    clean;
    word_t   exp_word;

    // word w of the zero padded MSB-first stream first, first+step and so on
    function automatic word_t stream_word(input int w, input sample_t first,
                                          input int step, input int total);
        word_t   wd;
        sample_t s;
        int      g;
        int      k;
        int      i;
        wd = '0;
        for (i = 0; i < WORD_W; i++) begin
            g = w * WORD_W + i;
            k = g / SAMPLE_W;
            s = (k < total) ? sample_t'(first + k * step) : '0;
            wd[WORD_W-1-i] = s[SAMPLE_W-1-(g % SAMPLE_W)];
        end
        return wd;
    endfunction

    assign new_arm  = arm_i && !armed_i;
    assign trig_evt = armed_i && capture_go_i && !trig_seen;
    // data is only predictable without a conflict and with a full history
    assign clean    = trig_seen && late_trig &&
                      !((cfg_i.presample != '0) && (cfg_i.downsample != '0));
    assign exp_word = stream_word(word_cnt, sample_t'(trig_val - cfg_i.presample),
                                  cfg_i.downsample + 1, cfg_i.max_samples);

    always_ff @(posedge adc_sampleclk) begin
        if (reset || new_arm) begin
            word_cnt  <= 0;
            arm_cyc   <= 0;
            trig_seen <= 1'b0;
            late_trig <= 1'b0;
        end else begin
            arm_cyc <= armed_i ? arm_cyc + 1 : 0;
            if (word_valid_i)
                word_cnt <= word_cnt + 1;
            if (trig_evt) begin
                trig_seen <= 1'b1;
                trig_val  <= adc_data_i;   // the trigger sample
                late_trig <= (cfg_i.presample == '0) || (arm_cyc > cfg_i.presample + 2);
            end
        end
    end

    a_reset: assert property (@(posedge adc_sampleclk) reset |=> !word_valid_i && !armed_i &&
        !capture_done_i && !error_flag_i && (error_stat_i == '0) && (state_i == st_idle))
        else begin
            fail_count++;
            $error("outputs not idle after reset");
        end

    a_arm: assert property (@(posedge adc_sampleclk) disable iff (reset)
        new_arm |=> armed_i && !error_flag_i && (error_stat_i == '0) &&
        (first_error_stat_i == '0))
        else begin
            fail_count++;
            $error("arm did not set armed or clear the status");
        end

    a_word: assert property (@(posedge adc_sampleclk) disable iff (reset)
        word_valid_i && clean |-> (word_i == exp_word))
        else begin
            fail_count++;
            $error("word %0d: got %h expected %h", word_cnt, word_i, exp_word);
        end

    a_count: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(capture_done_i) && clean |->
        (word_cnt == (cfg_i.max_samples * SAMPLE_W + WORD_W - 1) / WORD_W))
        else begin
            fail_count++;
            $error("wrong number of words: %0d", word_cnt);
        end

    a_done: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(capture_done_i) |-> $past(word_valid_i) && !armed_i)
        else begin
            fail_count++;
            $error("capture done not right after the last word");
        end

    a_clip: assert property (@(posedge adc_sampleclk) disable iff (reset)
        sample_valid_i && ((sample_i == '0) || (sample_i == '1)) |=>
        error_stat_i.clip && error_flag_i)
        else begin
            fail_count++;
            $error("clipped sample not flagged");
        end

    a_conflict: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(armed_i) && (cfg_i.presample != '0) && (cfg_i.downsample != '0) |->
        ##[1:3] error_stat_i.downsample_conflict)
        else begin
            fail_count++;
            $error("downsample conflict not flagged");
        end

    a_early: assert property (@(posedge adc_sampleclk) disable iff (reset)
        trig_evt && (cfg_i.presample != '0) && (arm_cyc < cfg_i.presample) |->
        ##[1:2] error_stat_i.early_trigger)
        else begin
            fail_count++;
            $error("early trigger not flagged");
        end

    a_no_early: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(capture_done_i) && clean |-> !error_stat_i.early_trigger)
        else begin
            fail_count++;
            $error("early trigger flagged on a late trigger");
        end

    a_flag: assert property (@(posedge adc_sampleclk) disable iff (reset)
        error_flag_i == (error_stat_i != '0))
        else begin
            fail_count++;
            $error("error flag does not match the status bits");
        end

    // first-error copy holds the bits of the first event only
    a_first: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(error_flag_i) |-> (first_error_stat_i == error_stat_i))
        else begin
            fail_count++;
            $error("first error bits differ from the first event");
        end

    // state seen on the cycle the first error was raised
    a_first_state: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(error_flag_i) |-> (first_error_state_i == $past(state_i)))
        else begin
            fail_count++;
            $error("first error state is not the state of the first event");
        end

    a_first_hold: assert property (@(posedge adc_sampleclk) disable iff (reset)
        error_flag_i && !arm_i |=> $stable(first_error_stat_i) &&
        $stable(first_error_state_i))
        else begin
            fail_count++;
            $error("first error copy changed after the first event");
        end

endmodule

//--- dv/tb_adc_capture.sv
`timescale 1ns/1ps

module tb_adc_capture import capture_pkg::*; ();

    logic           adc_sampleclk = 1'b0;
    logic           reset;
    sample_t        adc_data;
    logic           arm;
    logic           capture_go;
    capture_cfg_t   cfg;
    word_t          word;
    logic           word_valid;
    logic           armed;
    logic           capture_done;
    capture_state_e state;
    logic           error_flag;
    error_bits_t    error_stat;
    error_bits_t    first_error_stat;
    capture_state_e first_error_state;
    integer         seed = 58;

    always #2 adc_sampleclk = ~adc_sampleclk;   // 4 ns period

    adc_capture_top dut0 (
        .adc_sampleclk       (adc_sampleclk),
        .reset               (reset),
        .adc_data_i          (adc_data),
        .arm_i               (arm),
        .capture_go_i        (capture_go),
        .cfg_i               (cfg),
        .word_o              (word),
        .word_valid_o        (word_valid),
        .armed_o             (armed),
        .capture_done_o      (capture_done),
        .state_o             (state),
        .error_flag_o        (error_flag),
        .error_stat_o        (error_stat),
        .first_error_stat_o  (first_error_stat),
        .first_error_state_o (first_error_state)
    );

    bind adc_capture_top adc_capture_checker u_chk (
        .adc_sampleclk       (adc_sampleclk),
        .reset               (reset),
        .adc_data_i          (adc_data_i),
        .arm_i               (arm_i),
        .capture_go_i        (capture_go_i),
        .cfg_i               (cfg_i),
        .word_i              (word_o),
        .word_valid_i        (word_valid_o),
        .armed_i             (armed_o),
        .capture_done_i      (capture_done_o),
        .state_i             (state_o),
        .error_flag_i        (error_flag_o),
        .error_stat_i        (error_stat_o),
        .first_error_stat_i  (first_error_stat_o),
        .first_error_state_i (first_error_state_o),
        .sample_i            (fifo_data),
        .sample_valid_i      (sample_valid)
    );

    // ramp start well below 0xfff so no capture reaches it
    function automatic sample_t ramp_start();
        return sample_t'(12'h001 + ($random(seed) & 32'h3ff));
    endfunction

    // inputs move 0.5 ns after the edge and the ramp steps every cycle
    task automatic next_cycle();
        @(posedge adc_sampleclk);
        #0.5;
        adc_data = adc_data + 1'b1;
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout at %0t: %s never rose", $time, what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on a timeout");
    endtask

    task automatic wait_armed(input int limit);
        int n = 0;
        while (!armed && n < limit) begin
            next_cycle();
            n++;
        end
        if (!armed)
            timeout_fail("armed_o");
    endtask

    task automatic wait_done(input int limit);
        int n = 0;
        while (!capture_done && n < limit) begin
            next_cycle();
            n++;
        end
        if (!capture_done)
            timeout_fail("capture_done_o");
    endtask

    task automatic run_capture(input int pre, input int ds, input int total,
                               input sample_t start, input int trig_delay);
        cfg.presample   = PRESAMPLE_W'(pre);
        cfg.downsample  = DOWNSAMPLE_W'(ds);
        cfg.max_samples = COUNT_W'(total);
        adc_data        = start;
        arm             = 1'b1;
        next_cycle();
        arm = 1'b0;
        wait_armed(8);
        repeat (trig_delay)
            next_cycle();
        capture_go = 1'b1;   // held until the capture ends
        wait_done(2000);
        capture_go = 1'b0;
        repeat (3)
            next_cycle();
    endtask

    always @(dut0.u_chk.fail_count) begin
        if (dut0.u_chk.fail_count != 0) begin
            $display("[FAIL] %0t: checker assertion failed", $time);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopped at the first failed check");
        end
    end

    initial begin
        reset      = 1'b1;
        arm        = 1'b0;
        capture_go = 1'b0;
        cfg        = '0;
        adc_data   = 12'h001;
        repeat (4)
            next_cycle();
        reset = 1'b0;
        repeat (2)
            next_cycle();
        run_capture(0, 0, 40, ramp_start(), 8);    // plain capture
        run_capture(10, 0, 32, ramp_start(), 18);  // presamples
        run_capture(0, 3, 16, ramp_start(), 8);    // every 4th sample
        run_capture(0, 0, 20, 12'hff0, 8);         // ramp through zero for clip
        run_capture(4, 2, 12, ramp_start(), 12);   // downsample with presamples
        run_capture(20, 0, 24, 12'hff0, 0);        // early trigger with a later clip
        repeat (4)
            next_cycle();
        if (dut0.u_chk.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "checker reported failures");
        end
    end

endmodule

//--- hdl/adc_capture_top.sv
`timescale 1ns/1ps

module adc_capture_top import capture_pkg::*; (
    input  logic           adc_sampleclk,
    input  logic           reset,
    input  sample_t        adc_data_i,
    input  logic           arm_i,
    input  logic           capture_go_i,
    input  capture_cfg_t   cfg_i,          // stable while armed
    output word_t          word_o,
    output logic           word_valid_o,
    output logic           armed_o,
    output logic           capture_done_o,
    output capture_state_e state_o,
    output logic           error_flag_o,
    output error_bits_t    error_stat_o,
    output error_bits_t    first_error_stat_o,
    output capture_state_e first_error_state_o
);

    logic    fifo_wr;
    logic    fifo_drain;
    logic    fifo_rd_en;
    logic    fifo_empty;
    sample_t fifo_data;
    logic    sample_valid;
    logic    pad_req;
    logic    pad_done;
    logic    arm_pulse;
    logic    ds_conflict;
    logic    early_trigger;

    capture_fsm u_fsm (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .arm_i           (arm_i),
        .capture_go_i    (capture_go_i),
        .cfg_i           (cfg_i),
        .fifo_empty_i    (fifo_empty),
        .pad_done_i      (pad_done),
        .fifo_wr_o       (fifo_wr),
        .fifo_drain_o    (fifo_drain),
        .fifo_rd_en_o    (fifo_rd_en),
        .pad_req_o       (pad_req),
        .armed_o         (armed_o),
        .capture_done_o  (capture_done_o),
        .state_o         (state_o),
        .arm_pulse_o     (arm_pulse),
        .ds_conflict_o   (ds_conflict),
        .early_trigger_o (early_trigger)
    );

    sample_fifo u_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .wr_i          (fifo_wr),
        .drain_i       (fifo_drain),
        .rd_en_i       (fifo_rd_en),
        .data_i        (adc_data_i),
        .data_o        (fifo_data),
        .valid_o       (sample_valid),
        .empty_o       (fifo_empty)
    );

    word_packer u_packer (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .sample_i       (fifo_data),
        .sample_valid_i (sample_valid),
        .pad_req_i      (pad_req),
        .word_o         (word_o),
        .word_valid_o   (word_valid_o),
        .pad_done_o     (pad_done)
    );

    error_tracker u_errors (
        .adc_sampleclk       (adc_sampleclk),
        .reset               (reset),
        .sample_i            (fifo_data),
        .sample_valid_i      (sample_valid),
        .arm_pulse_i         (arm_pulse),
        .ds_conflict_i       (ds_conflict),
        .early_trigger_i     (early_trigger),
        .state_i             (state_o),
        .error_flag_o        (error_flag_o),
        .error_stat_o        (error_stat_o),
        .first_error_stat_o  (first_error_stat_o),
        .first_error_state_o (first_error_state_o)
    );

endmodule

//--- hdl/capture_fsm.sv
`timescale 1ns/1ps

module capture_fsm import capture_pkg::*; (
    input  logic           adc_sampleclk,
    input  logic           reset,
    input  logic           arm_i,
    input  logic           capture_go_i,
    input  capture_cfg_t   cfg_i,
    input  logic           fifo_empty_i,
    input  logic           pad_done_i,
    output logic           fifo_wr_o,
    output logic           fifo_drain_o,
    output logic           fifo_rd_en_o,
    output logic           pad_req_o,
    output logic           armed_o,
    output logic           capture_done_o,
    output capture_state_e state_o,
    output logic           arm_pulse_o,
    output logic           ds_conflict_o,
    output logic           early_trigger_o
);

    logic [COUNT_W-1:0]      sample_cnt;   // samples held or kept so far
    logic [COUNT_W-1:0]      cnt_inc;
    logic [COUNT_W-1:0]      pre_target;
    logic [DOWNSAMPLE_W-1:0] ds_cnt;
    logic                    ds_keep;
    logic                    last_sample;
    logic                    waiting;
    logic                    trig;
    logic                    leave_idle;
    logic                    has_presamples;

    assign has_presamples = (cfg_i.presample != '0);
    assign pre_target     = COUNT_W'(cfg_i.presample);
    assign cnt_inc        = sample_cnt + 1'b1;
    assign last_sample    = (cnt_inc >= cfg_i.max_samples);
    assign ds_keep        = (ds_cnt == cfg_i.downsample);

    // the trigger counts on the first clock it is seen high while armed
    assign waiting = (state_o == st_idle) || (state_o == st_pre_filling) ||
                     (state_o == st_pre_full);
    assign trig    = armed_o && capture_go_i && waiting;

    // arming only takes effect between captures
    assign arm_pulse_o = arm_i && (state_o == st_idle);

    assign leave_idle      = (state_o == st_idle) && armed_o && (trig || has_presamples);
    assign ds_conflict_o   = leave_idle && (cfg_i.downsample != '0) && has_presamples;
    assign early_trigger_o = trig && ((state_o == st_pre_filling) ||
                                      ((state_o == st_idle) && has_presamples));

    always_comb begin
        unique case (state_o)
            st_idle:                     fifo_wr_o = trig;     // trigger sample, no presamples
            st_pre_filling, st_pre_full: fifo_wr_o = 1'b1;     // history runs every cycle
            st_triggered:                fifo_wr_o = ds_keep;
            default:                     fifo_wr_o = 1'b0;
        endcase
    end

    assign fifo_drain_o = (state_o == st_pre_full) && !trig;  // hold exactly P presamples
    assign fifo_rd_en_o = (state_o == st_triggered) || (state_o == st_done);
    assign pad_req_o    = (state_o == st_done) && fifo_empty_i;

    // downsample phase restarts on the trigger so the trigger sample is kept
    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            ds_cnt <= '0;
        else if (trig || ds_keep)
            ds_cnt <= '0;
        else
            ds_cnt <= ds_cnt + 1'b1;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            armed_o        <= 1'b0;
            capture_done_o <= 1'b0;
        end else if (arm_pulse_o) begin
            armed_o        <= 1'b1;
            capture_done_o <= 1'b0;
        end else if ((state_o == st_done) && pad_done_i) begin
            armed_o        <= 1'b0;   // last word left one cycle ago
            capture_done_o <= 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state_o    <= st_idle;
            sample_cnt <= '0;
        end else if (trig) begin
            sample_cnt <= cnt_inc;   // presamples so far plus the trigger sample
            state_o    <= last_sample ? st_done : st_triggered;
        end else begin
            unique case (state_o)
                st_idle: begin
                    if (armed_o && has_presamples)
                        state_o <= st_pre_filling;
                end
                st_pre_filling: begin
                    sample_cnt <= cnt_inc;
                    if (cnt_inc == pre_target)
                        state_o <= st_pre_full;
                end
                st_pre_full: begin
                    state_o <= st_pre_full;   // write and drain until the trigger
                end
                st_triggered: begin
                    if (ds_keep) begin
                        sample_cnt <= cnt_inc;
                        if (last_sample)
                            state_o <= st_done;
                    end
                end
                st_done: begin
                    if (pad_done_i) begin
                        sample_cnt <= '0;
                        state_o    <= st_idle;
                    end
                end
                default: state_o <= st_idle;
            endcase
        end
    end

endmodule

//--- hdl/capture_pkg.sv
package capture_pkg;

    localparam int SAMPLE_W     = 12;
    localparam int WORD_W       = 64;
    localparam int SHIFT_W      = 6 * SAMPLE_W;    // packer shift register, 72 bits
    localparam int FIFO_DEPTH   = 64;              // presample count stays below FIFO_DEPTH - 3
    localparam int FIFO_AW      = $clog2(FIFO_DEPTH);
    localparam int PRESAMPLE_W  = 6;
    localparam int DOWNSAMPLE_W = 8;
    localparam int COUNT_W      = 16;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [WORD_W-1:0]   word_t;

    typedef enum logic [2:0] {
        st_idle,
        st_pre_filling,
        st_pre_full,
        st_triggered,
        st_done
    } capture_state_e;

    typedef struct packed {
        logic [PRESAMPLE_W-1:0]  presample;     // samples kept ahead of the trigger
        logic [DOWNSAMPLE_W-1:0] downsample;    // samples skipped between kept ones
        logic [COUNT_W-1:0]      max_samples;   // presamples plus kept samples
    } capture_cfg_t;

    typedef struct packed {
        logic clip;
        logic downsample_conflict;
        logic early_trigger;
    } error_bits_t;

endpackage

//--- hdl/error_tracker.sv
`timescale 1ns/1ps

module error_tracker import capture_pkg::*; (
    input  logic           adc_sampleclk,
    input  logic           reset,
    input  sample_t        sample_i,
    input  logic           sample_valid_i,
    input  logic           arm_pulse_i,
    input  logic           ds_conflict_i,
    input  logic           early_trigger_i,
    input  capture_state_e state_i,
    output logic           error_flag_o,
    output error_bits_t    error_stat_o,
    output error_bits_t    first_error_stat_o,
    output capture_state_e first_error_state_o
);

    error_bits_t new_bits;

    always_comb begin
        new_bits.clip                = sample_valid_i && ((sample_i == '1) || (sample_i == '0));
        new_bits.downsample_conflict = ds_conflict_i;
        new_bits.early_trigger       = early_trigger_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_pulse_i) begin
            error_flag_o        <= 1'b0;
            error_stat_o        <= '0;
            first_error_stat_o  <= '0;
            first_error_state_o <= st_idle;
        end else begin
            error_stat_o <= error_bits_t'(error_stat_o | new_bits);   // sticky
            if (new_bits != '0) begin
                error_flag_o <= 1'b1;
                if (!error_flag_o) begin
                    first_error_stat_o  <= new_bits;   // only bits of the first event
                    first_error_state_o <= state_i;
                end
            end
        end
    end

endmodule

//--- hdl/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo import capture_pkg::*; (
    input  logic    adc_sampleclk,
    input  logic    reset,
    input  logic    wr_i,
    input  logic    drain_i,
    input  logic    rd_en_i,
    input  sample_t data_i,
    output sample_t data_o,
    output logic    valid_o,
    output logic    empty_o
);

    sample_t            mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               do_wr;
    logic               do_rd;
    logic               pop;

    assign empty_o = (count == '0);
    assign full    = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign do_wr   = wr_i && !full;
    assign do_rd   = rd_en_i && !empty_o;             // read that goes downstream
    assign pop     = (rd_en_i || drain_i) && !empty_o;  // a drain just drops the oldest entry

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= do_rd;
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;   // pointers wrap, depth is a power of two
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and read data
    always_ff @(posedge adc_sampleclk) begin
        if (do_wr)
            mem[wr_ptr] <= data_i;
        if (do_rd)
            data_o <= mem[rd_ptr];
    end

endmodule

//--- hdl/word_packer.sv
`timescale 1ns/1ps

module word_packer import capture_pkg::*; (
    input  logic    adc_sampleclk,
    input  logic    reset,
    input  sample_t sample_i,
    input  logic    sample_valid_i,
    input  logic    pad_req_i,
    output word_t   word_o,
    output logic    word_valid_o,
    output logic    pad_done_o
);

    // 16 samples fill 3 words, phases take 6, 5 and 5 samples
    logic [SHIFT_W-1:0] shifter;
    logic [SHIFT_W-1:0] sh_next;
    logic [1:0]         phase;
    logic [2:0]         cnt;        // samples taken in this phase
    logic [2:0]         last_cnt;
    sample_t            in_sample;
    logic               aligned;
    logic               finishing;
    logic               shift_en;
    logic               complete;
    logic               finish_now;

    assign last_cnt  = (phase == 2'd0) ? 3'd5 : 3'd4;
    assign aligned   = (phase == 2'd0) && (cnt == 3'd0);   // no bits waiting in the shifter
    assign finishing = pad_req_i && !pad_done_o;
    assign shift_en  = sample_valid_i || (finishing && !aligned);
    assign in_sample = sample_valid_i ? sample_i : '0;     // zero sample while padding
    assign sh_next   = {shifter[SHIFT_W-SAMPLE_W-1:0], in_sample};
    assign complete  = shift_en && (cnt == last_cnt);

    // the final real sample may itself close the last word.
    // a word closed in phase 0 or 1 still leaves real bits behind
    always_comb begin
        if (!finishing)
            finish_now = 1'b0;
        else if (complete)
            finish_now = (phase == 2'd2) || !sample_valid_i;
        else
            finish_now = aligned && !sample_valid_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            phase        <= 2'd0;
            cnt          <= 3'd0;
            word_valid_o <= 1'b0;
            pad_done_o   <= 1'b0;
        end else begin
            word_valid_o <= complete;
            pad_done_o   <= finish_now;
            if (finish_now) begin
                phase <= 2'd0;   // ready for the next capture
                cnt   <= 3'd0;
            end else if (complete) begin
                phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
                cnt   <= 3'd0;
            end else if (shift_en) begin
                cnt <= cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (shift_en)
            shifter <= sh_next;
        if (complete) begin
            unique case (phase)
                2'd0:    word_o <= sh_next[SHIFT_W-1:8];      // 8 bits carried over
                2'd1:    word_o <= sh_next[WORD_W+3:4];       // 4 bits carried over
                default: word_o <= sh_next[WORD_W-1:0];
            endcase
        end
    end

endmodule

//--- vlog.f
hdl/capture_pkg.sv
hdl/sample_fifo.sv
hdl/capture_fsm.sv
hdl/word_packer.sv
hdl/error_tracker.sv
hdl/adc_capture_top.sv
dv/adc_capture_checker.sv
dv/tb_adc_capture.sv
